//--- rtl/spm_pkg.sv
// Shared widths and structs of the scratchpad; addresses above SpmIdxWidth bits wrap onto the SRAM
`default_nettype none

package spm_pkg;

  // ----------------------------------------
  // Geometry
  // ----------------------------------------
  localparam int unsigned SpmDataWidth  = 64;
  localparam int unsigned SpmBeWidth    = SpmDataWidth / 8;
  localparam int unsigned SpmNumWords   = 1024;
  localparam int unsigned SpmIdxWidth   = $clog2(SpmNumWords);
  localparam int unsigned SpmAddrWidth  = 32;
  localparam int unsigned SpmIdWidth    = 4;

  // Only 0 and 1 are supported by the controller
  localparam int unsigned SpmWaitStates = 1;

  // ----------------------------------------
  // Requester side
  // ----------------------------------------
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [SpmAddrWidth-1:0] addr;
    logic [SpmDataWidth-1:0] wdata;
    logic [SpmBeWidth-1:0]   be;
    logic [SpmIdWidth-1:0]   id;
  } spm_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    rvalid;
    logic [SpmDataWidth-1:0] rdata;
    logic                    killed;
    logic [SpmAddrWidth-1:0] addr;
    logic [SpmIdWidth-1:0]   rid;
  } spm_resp_t;

  // SRAM command, word indexed
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [SpmIdxWidth-1:0]  idx;
    logic [SpmDataWidth-1:0] wdata;
    logic [SpmBeWidth-1:0]   be;
  } spm_sram_req_t;

endpackage

`default_nettype wire

//--- rtl/sram_controller.sv
// Request controller; NumWaitState must be 0 or 1 and kill_s2 acts only in a read response cycle
`timescale 1ns/10ps
`default_nettype none

module sram_controller
  import spm_pkg::*;
#(
  parameter int unsigned NumWaitState = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  spm_req_t                req_i,
  input  logic                    kill_s1_i,
  input  logic                    kill_s2_i,
  output spm_resp_t               resp_o,
  output spm_sram_req_t           sram_o,
  input  logic [SpmDataWidth-1:0] sram_rdata_i
);

  logic                    gnt;
  logic                    rvalid;
  logic                    killed;
  logic                    sram_req;
  logic [SpmAddrWidth-1:0] addr_q;
  logic [SpmIdWidth-1:0]   rid_q;

  // The command strobe alone qualifies the payload sent to the SRAM
  assign sram_o = '{
    req:   sram_req,
    we:    req_i.we,
    idx:   req_i.addr[SpmIdxWidth-1:0],
    wdata: req_i.wdata,
    be:    req_i.be
  };

  assign resp_o = '{
    gnt:    gnt,
    rvalid: rvalid,
    rdata:  sram_rdata_i,
    killed: killed,
    addr:   addr_q,
    rid:    rid_q
  };

  if (NumWaitState == 1) begin : gen_wait_state

    typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ
    } state_e;

    state_e state_d, state_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q <= IDLE;
      end else begin
        state_q <= state_d;
      end
    end

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
      state_d = IDLE;
      if (state_q == IDLE && req_i.req && !kill_s1_i) begin
        state_d = req_i.we ? WRITE : READ;
      end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    always_comb begin
      gnt      = 1'b0;
      sram_req = 1'b0;
      rvalid   = 1'b0;
      // A stage-one kill flags the request of this cycle in every state
      killed   = req_i.req && kill_s1_i;
      case (state_q)
        IDLE: begin
          if (req_i.req && !kill_s1_i) begin
            gnt      = 1'b1;
            sram_req = 1'b1;
          end
        end
        READ: begin
          // SRAM data of the granted read is on sram_rdata_i now
          rvalid = !kill_s2_i;
          killed = killed || kill_s2_i;
        end
        default: ;
      endcase
    end

    // Back-pressure cycle holds off any grant
    a_no_back_to_back_gnt : assert property (
      @(posedge clk_i) disable iff (!rst_ni) gnt |=> !gnt
    );

  end else begin : gen_no_wait_state

    logic rvalid_q;

    assign gnt      = req_i.req && !kill_s1_i;
    assign sram_req = gnt;
    assign rvalid   = rvalid_q && !kill_s2_i;
    assign killed   = (req_i.req && kill_s1_i) || (rvalid_q && kill_s2_i);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rvalid_q <= 1'b0;
      end else begin
        rvalid_q <= gnt && !req_i.we;
      end
    end

  end

  // Address and id echo loaded at each grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rid_q  <= '0;
    end else if (gnt) begin
      addr_q <= req_i.addr;
      rid_q  <= req_i.id;
    end
  end

  // Nothing can be in flight in the first cycle out of reset
  a_no_rvalid_after_reset : assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !rvalid
  );

endmodule

`default_nettype wire

//--- rtl/spm_sram.sv
// Single-port 1024x64 SRAM model; read data appears one clock after the command, no read-during-write
`timescale 1ns/10ps
`default_nettype none

module spm_sram
  import spm_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  spm_sram_req_t           sram_i,
  output logic [SpmDataWidth-1:0] rdata_o
);

  logic [SpmDataWidth-1:0] mem_q [SpmNumWords];
  logic [SpmDataWidth-1:0] rdata_q;

  // ----------------------------------------
  // Array write with byte enables
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (sram_i.req && sram_i.we) begin
      for (int b = 0; b < SpmBeWidth; b++) begin
        if (sram_i.be[b]) begin
          mem_q[sram_i.idx][b*8 +: 8] <= sram_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read port register, holds its value between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (sram_i.req && !sram_i.we) begin
      rdata_q <= mem_q[sram_i.idx];
    end
  end

  assign rdata_o = rdata_q;

  a_idx_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni) sram_i.req |-> !$isunknown(sram_i.idx)
  );

endmodule

`default_nettype wire

//--- rtl/spm_port_arb.sv
// Load/store wins over fetch; fetch has no kills so killed always goes to load/store
`timescale 1ns/10ps
`default_nettype none

module spm_port_arb
  import spm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Load/store port
  input  spm_req_t  lsu_req_i,
  input  logic      lsu_kill_s1_i,
  input  logic      lsu_kill_s2_i,
  output spm_resp_t lsu_resp_o,
  // Fetch port
  input  spm_req_t  if_req_i,
  output spm_resp_t if_resp_o,
  // Towards the controller
  output spm_req_t  mem_req_o,
  output logic      mem_kill_s1_o,
  output logic      mem_kill_s2_o,
  input  spm_resp_t mem_resp_i
);

  logic sel_lsu;
  logic owner_lsu_q;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  assign sel_lsu       = lsu_req_i.req;
  assign mem_req_o     = sel_lsu ? lsu_req_i : if_req_i;
  assign mem_kill_s1_o = sel_lsu && lsu_kill_s1_i;

  // Stage two belongs to the response in flight and not to the current request
  assign mem_kill_s2_o = owner_lsu_q && lsu_kill_s2_i;

  // Owner of the item granted last points at load/store out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_lsu_q <= 1'b1;
    end else if (mem_resp_i.gnt) begin
      owner_lsu_q <= sel_lsu;
    end
  end

  // ----------------------------------------
  // Response routing
  // ----------------------------------------
  always_comb begin
    lsu_resp_o = '0;
    if_resp_o  = '0;

    // Request-cycle fields follow the current selection
    lsu_resp_o.gnt    = mem_resp_i.gnt && sel_lsu;
    if_resp_o.gnt     = mem_resp_i.gnt && !sel_lsu;
    lsu_resp_o.killed = mem_resp_i.killed;

    // Response-cycle fields follow the registered owner
    if (owner_lsu_q) begin
      lsu_resp_o.rvalid = mem_resp_i.rvalid;
      lsu_resp_o.rdata  = mem_resp_i.rdata;
      lsu_resp_o.addr   = mem_resp_i.addr;
      lsu_resp_o.rid    = mem_resp_i.rid;
    end else begin
      if_resp_o.rvalid = mem_resp_i.rvalid;
      if_resp_o.rdata  = mem_resp_i.rdata;
      if_resp_o.addr   = mem_resp_i.addr;
      if_resp_o.rid    = mem_resp_i.rid;
    end
  end

  // The owner register only names the right port one cycle after its grant
  a_rvalid_after_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_resp_i.rvalid |-> $past(mem_resp_i.gnt)
  );

endmodule

`default_nettype wire

//--- rtl/spm_top.sv
// Scratchpad top with one wait state; requesters must hold req and payload until gnt
`timescale 1ns/10ps
`default_nettype none

module spm_top
  import spm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  spm_req_t  lsu_req_i,
  input  logic      lsu_kill_s1_i,
  input  logic      lsu_kill_s2_i,
  output spm_resp_t lsu_resp_o,
  input  spm_req_t  if_req_i,
  output spm_resp_t if_resp_o
);

  spm_req_t                arb_req;
  logic                    arb_kill_s1;
  logic                    arb_kill_s2;
  spm_resp_t               ctrl_resp;
  spm_sram_req_t           sram_req;
  logic [SpmDataWidth-1:0] sram_rdata;

  spm_port_arb u_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lsu_req_i     (lsu_req_i),
    .lsu_kill_s1_i (lsu_kill_s1_i),
    .lsu_kill_s2_i (lsu_kill_s2_i),
    .lsu_resp_o    (lsu_resp_o),
    .if_req_i      (if_req_i),
    .if_resp_o     (if_resp_o),
    .mem_req_o     (arb_req),
    .mem_kill_s1_o (arb_kill_s1),
    .mem_kill_s2_o (arb_kill_s2),
    .mem_resp_i    (ctrl_resp)
  );

  sram_controller #(
    .NumWaitState (SpmWaitStates)
  ) u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (arb_req),
    .kill_s1_i    (arb_kill_s1),
    .kill_s2_i    (arb_kill_s2),
    .resp_o       (ctrl_resp),
    .sram_o       (sram_req),
    .sram_rdata_i (sram_rdata)
  );

  spm_sram u_sram (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .sram_i  (sram_req),
    .rdata_o (sram_rdata)
  );

endmodule

`default_nettype wire

//--- test/tb_spm.sv
// Directed testbench for spm_top; it reads only written words since the SRAM array has no reset
`timescale 1ns/10ps
`default_nettype none

module tb_spm
  import spm_pkg::*;
();

  localparam int ClkPeriod  = 100;
  localparam int RandOps    = 80;
  // Each access takes at most 4 cycles and the directed part needs about 60
  localparam int TestCycles = 60 + RandOps * 4;
  localparam int MarginNs   = 5000;

  logic      clk;
  logic      rst_n;
  spm_req_t  lsu_req;
  logic      lsu_kill_s1;
  logic      lsu_kill_s2;
  spm_resp_t lsu_resp;
  spm_req_t  if_req;
  spm_resp_t if_resp;

  logic [SpmDataWidth-1:0] model_mem [SpmNumWords];
  bit                      known [SpmNumWords];
  integer                  seed;
  int                      err_count;
  int                      tests_passed;
  int                      tests_failed;

  spm_top dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .lsu_req_i     (lsu_req),
    .lsu_kill_s1_i (lsu_kill_s1),
    .lsu_kill_s2_i (lsu_kill_s2),
    .lsu_resp_o    (lsu_resp),
    .if_req_i      (if_req),
    .if_resp_o     (if_resp)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  initial begin : watchdog
    #(TestCycles * ClkPeriod + MarginNs);
    $display("Timeout: the tests did not finish within %0d clock cycles", TestCycles);
    $display("TEST FAILED");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d errors", name, err_count - errs_at_start);
    end
  endtask

  // Only enabled bytes of the reference memory change
  task automatic model_write(input logic [31:0] addr, input logic [63:0] wdata,
                             input logic [7:0] be);
    logic [SpmIdxWidth-1:0] idx;
    idx = addr[SpmIdxWidth-1:0];
    for (int b = 0; b < SpmBeWidth; b++) begin
      if (be[b]) begin
        model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    known[idx] = 1'b1;
  endtask

  // Request stays on the port until gnt is seen after the inputs settle
  task automatic wait_gnt(input bit fetch_port);
    while (fetch_port ? !if_resp.gnt : !lsu_resp.gnt) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [63:0] wdata,
                            input logic [7:0] be, input logic [3:0] id, input bit kill_s1);
    @(negedge clk);
    lsu_req       = '0;
    lsu_req.req   = 1'b1;
    lsu_req.we    = 1'b1;
    lsu_req.addr  = addr;
    lsu_req.wdata = wdata;
    lsu_req.be    = be;
    lsu_req.id    = id;
    lsu_kill_s1   = kill_s1;
    lsu_kill_s2   = 1'b0;
    #1;
    if (kill_s1) begin
      check_value(64'(lsu_resp.gnt), 64'd0, "gnt of a killed write");
      check_value(64'(lsu_resp.killed), 64'd1, "killed of a killed write");
    end else begin
      wait_gnt(1'b0);
      check_value(64'(lsu_resp.killed), 64'd0, "killed of a write");
      // A write is complete at its grant
      model_write(addr, wdata, be);
    end
    @(negedge clk);
    lsu_req.req = 1'b0;
    lsu_kill_s1 = 1'b0;
  endtask

  task automatic read_word(input bit fetch_port, input logic [31:0] addr,
                           input logic [3:0] id, input bit kill_s2);
    spm_req_t  rd;
    spm_resp_t own;
    spm_resp_t other;
    rd      = '0;
    rd.req  = 1'b1;
    rd.addr = addr;
    rd.id   = id;
    @(negedge clk);
    if (fetch_port) begin
      if_req = rd;
    end else begin
      lsu_req = rd;
    end
    lsu_kill_s1 = 1'b0;
    lsu_kill_s2 = 1'b0;
    #1;
    wait_gnt(fetch_port);
    own = fetch_port ? if_resp : lsu_resp;
    check_value(64'(own.rvalid), 64'd0, "rvalid in the grant cycle");
    // Response cycle
    @(negedge clk);
    lsu_req.req = 1'b0;
    if_req.req  = 1'b0;
    lsu_kill_s2 = kill_s2;
    #1;
    own   = fetch_port ? if_resp : lsu_resp;
    other = fetch_port ? lsu_resp : if_resp;
    check_value(64'(other.rvalid), 64'd0, "rvalid on the other port");
    if (kill_s2) begin
      check_value(64'(own.rvalid), 64'd0, "rvalid of a stage-two kill");
      check_value(64'(own.killed), 64'd1, "killed of a stage-two kill");
    end else begin
      check_value(64'(own.rvalid), 64'd1, "rvalid one cycle after grant");
      check_value(own.rdata, model_mem[addr[SpmIdxWidth-1:0]], "read data");
      check_value(64'(own.rid), 64'(id), "echoed id");
      check_value(64'(own.addr), 64'(addr), "echoed address");
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic reset_state();
    int errs;
    errs = err_count;
    check_value(64'(lsu_resp.gnt), 64'd0, "lsu gnt after reset");
    check_value(64'(lsu_resp.rvalid), 64'd0, "lsu rvalid after reset");
    check_value(64'(lsu_resp.killed), 64'd0, "lsu killed after reset");
    check_value(64'(if_resp.gnt), 64'd0, "fetch gnt after reset");
    check_value(64'(if_resp.rvalid), 64'd0, "fetch rvalid after reset");
    check_value(64'(if_resp.killed), 64'd0, "fetch killed after reset");
    check_value(64'(lsu_resp.addr), 64'd0, "echoed address after reset");
    check_value(64'(lsu_resp.rid), 64'd0, "echoed id after reset");
    report_test("reset state", errs);
  endtask

  task automatic write_read_back();
    int errs;
    errs = err_count;
    write_word(32'h0000_0123, {$random(seed), $random(seed)}, 8'hff, 4'h1, 1'b0);
    write_word(32'h0000_0123, {$random(seed), $random(seed)}, 8'h5a, 4'h2, 1'b0);
    // Upper address bits wrap onto the same word
    read_word(1'b0, 32'h7000_0123, 4'h5, 1'b0);
    report_test("write and read back", errs);
  endtask

  task automatic stage_one_kill();
    int errs;
    errs = err_count;
    write_word(32'h0000_0200, {$random(seed), $random(seed)}, 8'hff, 4'h3, 1'b0);
    write_word(32'h0000_0200, {$random(seed), $random(seed)}, 8'hff, 4'h6, 1'b1);
    read_word(1'b0, 32'h0000_0200, 4'h7, 1'b0);
    report_test("stage-one kill", errs);
  endtask

  task automatic stage_two_kill();
    int errs;
    errs = err_count;
    write_word(32'h0000_03ff, {$random(seed), $random(seed)}, 8'hff, 4'h8, 1'b0);
    read_word(1'b0, 32'h0000_03ff, 4'h9, 1'b1);
    read_word(1'b0, 32'h0000_03ff, 4'ha, 1'b0);
    report_test("stage-two kill", errs);
  endtask

  task automatic port_priority();
    int errs;
    errs = err_count;
    write_word(32'h0000_0010, {$random(seed), $random(seed)}, 8'hff, 4'h1, 1'b0);
    write_word(32'h0000_0020, {$random(seed), $random(seed)}, 8'hff, 4'h2, 1'b0);
    @(negedge clk);
    lsu_req      = '0;
    lsu_req.req  = 1'b1;
    lsu_req.addr = 32'h0000_0010;
    lsu_req.id   = 4'h3;
    if_req       = '0;
    if_req.req   = 1'b1;
    if_req.addr  = 32'h0000_0020;
    if_req.id    = 4'hc;
    #1;
    check_value(64'(lsu_resp.gnt), 64'd1, "lsu wins the tie");
    check_value(64'(if_resp.gnt), 64'd0, "fetch loses the tie");
    @(negedge clk);
    lsu_req.req = 1'b0;
    #1;
    check_value(64'(lsu_resp.rvalid), 64'd1, "lsu rvalid");
    check_value(lsu_resp.rdata, model_mem[10'h010], "lsu read data");
    check_value(64'(lsu_resp.rid), 64'h3, "lsu rid");
    check_value(64'(lsu_resp.addr), 64'h10, "lsu echoed address");
    check_value(64'(if_resp.rvalid), 64'd0, "fetch rvalid during lsu response");
    check_value(64'(if_resp.gnt), 64'd0, "fetch gnt during back-pressure");
    @(negedge clk);
    #1;
    check_value(64'(if_resp.gnt), 64'd1, "fetch gnt two cycles later");
    @(negedge clk);
    if_req.req = 1'b0;
    #1;
    check_value(64'(if_resp.rvalid), 64'd1, "fetch rvalid");
    check_value(if_resp.rdata, model_mem[10'h020], "fetch read data");
    check_value(64'(if_resp.rid), 64'hc, "fetch rid");
    check_value(64'(if_resp.addr), 64'h20, "fetch echoed address");
    check_value(64'(lsu_resp.rvalid), 64'd0, "lsu rvalid during fetch response");
    report_test("port priority", errs);
  endtask

  task automatic random_traffic();
    logic [31:0]            rnd;
    logic [31:0]            addr;
    logic [SpmIdxWidth-1:0] idx;
    logic [7:0]             be;
    int                     errs;
    errs = err_count;
    for (int i = 0; i < RandOps; i++) begin
      rnd = $random(seed);
      // Small window of words so that reads often hit earlier writes
      idx  = {4'b0000, rnd[5:0]};
      addr = {rnd[31:16], 6'b000000, idx};
      if (!known[idx] || rnd[6]) begin
        be = known[idx] ? rnd[15:8] : 8'hff;
        write_word(addr, {$random(seed), $random(seed)}, be, rnd[11:8], 1'b0);
      end else begin
        read_word(rnd[7], addr, rnd[11:8], 1'b0);
      end
    end
    report_test("random traffic", errs);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    seed         = 15;
    err_count    = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_n        = 1'b0;
    lsu_req      = '0;
    lsu_kill_s1  = 1'b0;
    lsu_kill_s2  = 1'b0;
    if_req       = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    reset_state();
    write_read_back();
    stage_one_kill();
    stage_two_kill();
    port_priority();
    random_traffic();
    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
rtl/spm_pkg.sv
rtl/sram_controller.sv
rtl/spm_sram.sv
rtl/spm_port_arb.sv
rtl/spm_top.sv
test/tb_spm.sv

//--- Makefile
# Verilator build and run of the scratchpad testbench

VERILATOR ?= verilator
TOP       ?= tb_spm
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

# Sources come from the file list, so the binary is rebuilt only when one changes
SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
